// ==== src/vstu_pkg.sv ====
/*
 * Shared constants and types of the vector store unit.
 * Element words, strobes, instruction ids, lengths and byte counts
 */

package vstu_pkg;

  ////////////////////////////////////////////////////
  // Lane element word
  ////////////////////////////////////////////////////

  // Bytes held by one lane word
  localparam int unsigned ElenBytes = 8;

  // One lane's element word and its byte strobes
  typedef logic [ElenBytes*8-1:0] elen_t;
  typedef logic [ElenBytes-1:0]   strb_t;

  ////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////

  // Ids in flight across the whole machine
  localparam int unsigned NrVInsn = 8;
  typedef logic [$clog2(NrVInsn)-1:0] vinsn_id_t;

  // Element width code, bytes per element is 1 << code
  typedef logic [1:0] vsew_t;

  // Vector length in elements
  typedef logic [15:0] vl_t;

  // AXI burst length field, beats minus one
  typedef logic [7:0] axi_len_t;

  // Remaining bytes of one instruction, fits vl << 3
  typedef logic [18:0] byte_cnt_t;

endpackage

// ==== src/vstu_insn_queue.sv ====
/*
 * In-order queue of store instructions.
 * Accept, issue and commit pointers over a circular buffer,
 * B-channel commit and one-hot completion report
 */

`timescale 1ns/100ps

module vstu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Sequencer requests
  input  logic                           req_valid_i,
  input  vstu_pkg::vinsn_id_t            req_id_i,
  input  vstu_pkg::vl_t                  req_vl_i,
  input  vstu_pkg::vsew_t                req_vsew_i,
  output logic                           req_ready_o,
  // Instruction under issue
  output logic                           issue_valid_o,
  output vstu_pkg::vl_t                  issue_vl_o,
  output vstu_pkg::vsew_t                issue_vsew_o,
  input  logic                           issue_done_i,
  // B channel
  input  logic                           b_valid_i,
  output logic                           b_ready_o,
  // Completion and status
  output logic [vstu_pkg::NrVInsn-1:0]   done_o,
  output logic                           pending_o
);

  import vstu_pkg::*;

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  // Instruction storage
  vinsn_id_t id_q   [InsnQueueDepth];
  vl_t       vl_q   [InsnQueueDepth];
  vsew_t     vsew_q [InsnQueueDepth];

  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Issue count covers unissued entries, commit count all live ones
  logic [CntW-1:0] issue_cnt_q, issue_cnt_d;
  logic [CntW-1:0] commit_cnt_q, commit_cnt_d;

  logic               accept, b_hs, commit;
  logic               b_ready_q;
  logic [NrVInsn-1:0] done_d, done_q;

  // Wrap a pointer at the queue depth
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(InsnQueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////

  assign req_ready_o = (commit_cnt_q != CntW'(InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;
  assign b_ready_o   = b_ready_q;
  assign b_hs        = b_valid_i && b_ready_q;
  // Only an issued and uncommitted entry can retire
  assign commit      = b_hs && (commit_cnt_q > issue_cnt_q);

  // Head of the unissued part
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_vl_o    = vl_q[issue_pnt_q];
  assign issue_vsew_o  = vsew_q[issue_pnt_q];

  assign pending_o = (commit_cnt_q != '0);
  assign done_o    = done_q;

  always_comb begin
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    done_d       = '0;
    if (accept) begin
      issue_cnt_d  = issue_cnt_d + CntW'(1);
      commit_cnt_d = commit_cnt_d + CntW'(1);
    end
    if (issue_done_i) begin
      issue_cnt_d = issue_cnt_d - CntW'(1);
    end
    if (commit) begin
      commit_cnt_d              = commit_cnt_d - CntW'(1);
      done_d[id_q[commit_pnt_q]] = 1'b1;
    end
  end

  // Payload written at the accept pointer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]   <= req_id_i;
      vl_q[accept_pnt_q]   <= req_vl_i;
      vsew_q[accept_pnt_q] <= req_vsew_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      b_ready_q    <= 1'b0;
      done_q       <= '0;
    end else begin
      if (accept) accept_pnt_q <= ptr_inc(accept_pnt_q);
      if (issue_done_i) issue_pnt_q <= ptr_inc(issue_pnt_q);
      if (commit) commit_pnt_q <= ptr_inc(commit_pnt_q);
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      b_ready_q    <= 1'b1;
      done_q       <= done_d;
    end
  end

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////

  // Occupancy stays within the depth, unissued entries within the live ones
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_cnt_q <= CntW'(InsnQueueDepth)) && (issue_cnt_q <= commit_cnt_q));

  // The packer only finishes an instruction that is under issue
  a_done_has_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> issue_valid_o);

endmodule

// ==== src/vstu_operand_reg.sv ====
/*
 * One-entry fall-through register for a lane operand.
 * Forwards when empty, holds the word while the packer stalls
 */

`timescale 1ns/100ps

module vstu_operand_reg (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Lane side
  input  vstu_pkg::elen_t data_i,
  input  logic            valid_i,
  output logic            ready_o,
  // Packer side
  output vstu_pkg::elen_t data_o,
  output logic            valid_o,
  input  logic            ready_i
);

  import vstu_pkg::*;

  elen_t data_q;
  logic  full_q;

  // Stored word has priority over the lane input
  assign ready_o = !full_q;
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;

  // Capture when a forwarded word is not taken
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !ready_i;
    end else begin
      full_q <= valid_i && !ready_i;
    end
  end

  // Offered word survives a stall unchanged
  a_stable_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// ==== src/vstu_beat_packer.sv ====
/*
 * W-channel beat builder of the store unit.
 * Packs one word per lane into a beat, tracks instruction bytes
 * and beats within the current address-generator burst
 */

`timescale 1ns/100ps

module vstu_beat_packer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Instruction under issue
  input  logic                                        issue_valid_i,
  input  vstu_pkg::vl_t                               issue_vl_i,
  input  vstu_pkg::vsew_t                             issue_vsew_i,
  output logic                                        issue_done_o,
  // Lane operands
  input  vstu_pkg::elen_t [NrLanes-1:0]               operand_i,
  input  logic [NrLanes-1:0]                          operand_valid_i,
  output logic                                        operand_ready_o,
  // Address generator
  input  logic                                        addrgen_valid_i,
  input  vstu_pkg::axi_len_t                          addrgen_len_i,
  output logic                                        addrgen_ready_o,
  // W channel
  output logic [NrLanes*vstu_pkg::ElenBytes*8-1:0]    axi_w_data_o,
  output logic [NrLanes*vstu_pkg::ElenBytes-1:0]      axi_w_strb_o,
  output logic                                        axi_w_last_o,
  output logic                                        axi_w_valid_o,
  input  logic                                        axi_w_ready_i
);

  import vstu_pkg::*;

  localparam int unsigned BeatBytes    = NrLanes * ElenBytes;
  localparam byte_cnt_t   BeatBytesCnt = byte_cnt_t'(BeatBytes);

  byte_cnt_t bytes_q, bytes_d;
  byte_cnt_t cur_bytes;
  axi_len_t  beat_q, beat_d;
  logic      beat_avail, w_hs;
  logic      burst_last, insn_last;

  ////////////////////////////////////////////////////
  // Beat control
  ////////////////////////////////////////////////////

  // Zero count means a fresh instruction, take its size directly
  assign cur_bytes = (bytes_q == '0) ? (byte_cnt_t'(issue_vl_i) << issue_vsew_i) : bytes_q;

  // All sources present, beat offered regardless of W ready
  assign beat_avail = issue_valid_i && addrgen_valid_i && (&operand_valid_i) &&
                      (cur_bytes != '0);
  assign w_hs       = beat_avail && axi_w_ready_i;

  assign burst_last = (beat_q == addrgen_len_i);
  // Final beat of the instruction
  assign insn_last  = (cur_bytes <= BeatBytesCnt);

  assign axi_w_valid_o   = beat_avail;
  assign axi_w_last_o    = burst_last;
  // Lanes advance together, one word each per beat
  assign operand_ready_o = w_hs;
  // Burst request retires with its last beat
  assign addrgen_ready_o = w_hs && burst_last;
  // Empty instructions retire without any beat
  assign issue_done_o    = issue_valid_i && ((cur_bytes == '0) || (w_hs && insn_last));

  ////////////////////////////////////////////////////
  // Beat payload
  ////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned lane = 0; lane < NrLanes; lane++) begin
      axi_w_data_o[lane*ElenBytes*8 +: ElenBytes*8] = operand_i[lane];
    end
  end

  // Strobe only the bytes still owed by the instruction
  always_comb begin
    for (int unsigned b = 0; b < BeatBytes; b++) begin
      axi_w_strb_o[b] = (byte_cnt_t'(b) < cur_bytes);
    end
  end

  ////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////

  always_comb begin
    bytes_d = bytes_q;
    beat_d  = beat_q;
    if (w_hs) begin
      // Floor at zero on the short final beat
      bytes_d = insn_last ? '0 : cur_bytes - BeatBytesCnt;
      beat_d  = burst_last ? '0 : beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bytes_q <= '0;
      beat_q  <= '0;
    end else begin
      bytes_q <= bytes_d;
      beat_q  <= beat_d;
    end
  end

  // A stalled beat keeps its instruction and payload until taken
  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && !axi_w_ready_i |=>
      axi_w_valid_o && issue_valid_i && $stable(axi_w_data_o) && $stable(axi_w_strb_o));

endmodule

// ==== src/vstu_top.sv ====
/*
 * Vector store unit top level.
 * Instruction queue, per-lane operand registers and beat packer
 */

`timescale 1ns/100ps

module vstu_top #(
  parameter int unsigned NrLanes        = 4,
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  logic                                        pe_req_valid_i,
  input  vstu_pkg::vinsn_id_t                         pe_req_id_i,
  input  vstu_pkg::vl_t                               pe_req_vl_i,
  input  vstu_pkg::vsew_t                             pe_req_vsew_i,
  output logic                                        pe_req_ready_o,
  output logic [vstu_pkg::NrVInsn-1:0]                pe_vinsn_done_o,
  // Lanes
  input  vstu_pkg::elen_t [NrLanes-1:0]               stu_operand_i,
  input  logic [NrLanes-1:0]                          stu_operand_valid_i,
  output logic [NrLanes-1:0]                          stu_operand_ready_o,
  // Address generator
  input  logic                                        addrgen_valid_i,
  input  vstu_pkg::axi_len_t                          addrgen_len_i,
  output logic                                        addrgen_ready_o,
  // AXI W and B
  output logic [NrLanes*vstu_pkg::ElenBytes*8-1:0]    axi_w_data_o,
  output logic [NrLanes*vstu_pkg::ElenBytes-1:0]      axi_w_strb_o,
  output logic                                        axi_w_last_o,
  output logic                                        axi_w_valid_o,
  input  logic                                        axi_w_ready_i,
  input  logic                                        axi_b_valid_i,
  output logic                                        axi_b_ready_o,
  // Status
  output logic                                        store_pending_o
);

  import vstu_pkg::*;

  // Queue to packer
  logic  issue_valid, issue_done;
  vl_t   issue_vl;
  vsew_t issue_vsew;

  // Operand registers to packer
  elen_t [NrLanes-1:0] operand;
  logic  [NrLanes-1:0] operand_valid;
  logic                operand_ready;

  vstu_insn_queue #(
    .InsnQueueDepth(InsnQueueDepth)
  ) insn_queue_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (pe_req_valid_i),
    .req_id_i     (pe_req_id_i),
    .req_vl_i     (pe_req_vl_i),
    .req_vsew_i   (pe_req_vsew_i),
    .req_ready_o  (pe_req_ready_o),
    .issue_valid_o(issue_valid),
    .issue_vl_o   (issue_vl),
    .issue_vsew_o (issue_vsew),
    .issue_done_i (issue_done),
    .b_valid_i    (axi_b_valid_i),
    .b_ready_o    (axi_b_ready_o),
    .done_o       (pe_vinsn_done_o),
    .pending_o    (store_pending_o)
  );

  // One decoupling register per lane, all drained together
  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_operand_reg
    vstu_operand_reg operand_reg_i (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .data_i (stu_operand_i[lane]),
      .valid_i(stu_operand_valid_i[lane]),
      .ready_o(stu_operand_ready_o[lane]),
      .data_o (operand[lane]),
      .valid_o(operand_valid[lane]),
      .ready_i(operand_ready)
    );
  end

  vstu_beat_packer #(
    .NrLanes(NrLanes)
  ) beat_packer_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_vl_i     (issue_vl),
    .issue_vsew_i   (issue_vsew),
    .issue_done_o   (issue_done),
    .operand_i      (operand),
    .operand_valid_i(operand_valid),
    .operand_ready_o(operand_ready),
    .addrgen_valid_i(addrgen_valid_i),
    .addrgen_len_i  (addrgen_len_i),
    .addrgen_ready_o(addrgen_ready_o),
    .axi_w_data_o   (axi_w_data_o),
    .axi_w_strb_o   (axi_w_strb_o),
    .axi_w_last_o   (axi_w_last_o),
    .axi_w_valid_o  (axi_w_valid_o),
    .axi_w_ready_i  (axi_w_ready_i)
  );

endmodule

// ==== verif/tb_vstu.sv ====
/*
 * Testbench of the vector store unit top level.
 * Clock, reset, LFSR-driven lanes, address generator and W ready,
 * reference queues and the checking assertions
 */

`timescale 1ns/100ps

module tb_vstu;

  import vstu_pkg::*;

  localparam int unsigned NrLanes        = 4;
  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned BeatBytes      = NrLanes * ElenBytes;
  localparam int unsigned MaxWait        = 2000;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         pe_req_valid_i;
  vinsn_id_t                    pe_req_id_i;
  vl_t                          pe_req_vl_i;
  vsew_t                        pe_req_vsew_i;
  logic                         pe_req_ready_o;
  logic [NrVInsn-1:0]           pe_vinsn_done_o;
  elen_t [NrLanes-1:0]          stu_operand_i;
  logic [NrLanes-1:0]           stu_operand_valid_i;
  logic [NrLanes-1:0]           stu_operand_ready_o;
  logic                         addrgen_valid_i;
  axi_len_t                     addrgen_len_i;
  logic                         addrgen_ready_o;
  logic [BeatBytes*8-1:0]       axi_w_data_o;
  logic [BeatBytes-1:0]         axi_w_strb_o;
  logic                         axi_w_last_o;
  logic                         axi_w_valid_o;
  logic                         axi_w_ready_i;
  logic                         axi_b_valid_i;
  logic                         axi_b_ready_o;
  logic                         store_pending_o;

  // Expected values, refreshed 1 ns after each edge
  logic [BeatBytes*8-1:0] exp_data;
  logic [BeatBytes-1:0]   exp_strb;
  logic                   exp_last, exp_beat, exp_req_ready, exp_pending;
  logic [NrVInsn-1:0]     exp_done;

  // Reference model state
  elen_t       lane_q [NrLanes][$];
  axi_len_t    burst_q [$];
  vinsn_id_t   unissued_id_q [$];
  int unsigned unissued_bytes_q [$];
  vinsn_id_t   issued_q [$];
  int unsigned rem_bytes, beat_in_burst, occupancy, beats_seen, beats_expected;

  // Handshakes seen at the last rising edge
  logic               w_hs_s, b_hs_s, acc_s, ag_hs_s;
  logic [NrLanes-1:0] lane_hs_s;
  vinsn_id_t          acc_id_s;
  int unsigned        acc_bytes_s;

  int unsigned data_errors, ctrl_errors, timeout_errors;
  logic [31:0] lfsr_q;

  vstu_top #(
    .NrLanes       (NrLanes),
    .InsnQueueDepth(InsnQueueDepth)
  ) vstu_top_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pe_req_valid_i     (pe_req_valid_i),
    .pe_req_id_i        (pe_req_id_i),
    .pe_req_vl_i        (pe_req_vl_i),
    .pe_req_vsew_i      (pe_req_vsew_i),
    .pe_req_ready_o     (pe_req_ready_o),
    .pe_vinsn_done_o    (pe_vinsn_done_o),
    .stu_operand_i      (stu_operand_i),
    .stu_operand_valid_i(stu_operand_valid_i),
    .stu_operand_ready_o(stu_operand_ready_o),
    .addrgen_valid_i    (addrgen_valid_i),
    .addrgen_len_i      (addrgen_len_i),
    .addrgen_ready_o    (addrgen_ready_o),
    .axi_w_data_o       (axi_w_data_o),
    .axi_w_strb_o       (axi_w_strb_o),
    .axi_w_last_o       (axi_w_last_o),
    .axi_w_valid_o      (axi_w_valid_o),
    .axi_w_ready_i      (axi_w_ready_i),
    .axi_b_valid_i      (axi_b_valid_i),
    .axi_b_ready_o      (axi_b_ready_o),
    .store_pending_o    (store_pending_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  //////////////////////////////////////////////////
  // Reference model and source drivers
  //////////////////////////////////////////////////

  // Retire B, W, burst and accept events of the last edge
  task automatic update_model();
    vinsn_id_t id;
    exp_done = '0;
    // B sees the state before this edge's final beat
    if (b_hs_s && issued_q.size() > 0) begin
      id           = issued_q.pop_front();
      exp_done[id] = 1'b1;
      occupancy--;
    end
    if (w_hs_s) begin
      for (int l = 0; l < NrLanes; l++) void'(lane_q[l].pop_front());
      beats_seen++;
      if (rem_bytes > BeatBytes) begin
        rem_bytes -= BeatBytes;
      end else begin
        rem_bytes = 0;
        issued_q.push_back(unissued_id_q.pop_front());
        void'(unissued_bytes_q.pop_front());
      end
      beat_in_burst = exp_last ? 0 : beat_in_burst + 1;
    end
    if (ag_hs_s) void'(burst_q.pop_front());
    if (acc_s) begin
      unissued_id_q.push_back(acc_id_s);
      unissued_bytes_q.push_back(acc_bytes_s);
      occupancy++;
    end
  endtask

  task automatic drive_sources();
    elen_t word;
    // A lane offers a new word only once the last one is taken
    for (int l = 0; l < NrLanes; l++) begin
      if (lane_hs_s[l] || !stu_operand_valid_i[l]) begin
        if (rand_bits(2) != 0) begin
          word                   = {rand_bits(32), rand_bits(32)};
          stu_operand_i[l]       = word;
          stu_operand_valid_i[l] = 1'b1;
          lane_q[l].push_back(word);
        end else begin
          stu_operand_valid_i[l] = 1'b0;
        end
      end
    end
    axi_w_ready_i   = (rand_bits(2) != 0);
    addrgen_valid_i = (burst_q.size() != 0);
    addrgen_len_i   = addrgen_valid_i ? burst_q[0] : '0;
  endtask

  task automatic compute_expected();
    for (int l = 0; l < NrLanes; l++) begin
      exp_data[l*64 +: 64] = (lane_q[l].size() > 0) ? lane_q[l][0] : '0;
    end
    // Next instruction starts when the current one is used up
    if (rem_bytes == 0 && unissued_bytes_q.size() > 0) rem_bytes = unissued_bytes_q[0];
    exp_beat = (rem_bytes != 0);
    for (int b = 0; b < BeatBytes; b++) exp_strb[b] = (b < rem_bytes);
    exp_last      = (burst_q.size() > 0) && (beat_in_burst == burst_q[0]);
    exp_req_ready = (occupancy != InsnQueueDepth);
    exp_pending   = (occupancy != 0);
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      w_hs_s      = axi_w_valid_o && axi_w_ready_i;
      b_hs_s      = axi_b_valid_i && axi_b_ready_o;
      acc_s       = pe_req_valid_i && pe_req_ready_o;
      ag_hs_s     = addrgen_valid_i && addrgen_ready_o;
      lane_hs_s   = stu_operand_valid_i & stu_operand_ready_o;
      acc_id_s    = pe_req_id_i;
      acc_bytes_s = int'(pe_req_vl_i) << pe_req_vsew_i;
      #1;
      update_model();
      drive_sources();
      compute_expected();
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_beat_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && axi_w_ready_i |-> axi_w_data_o == exp_data)
    else begin
      data_errors++;
      $display("FAIL beat_data: expected %h, actual %h", $sampled(exp_data),
               $sampled(axi_w_data_o));
    end

  a_beat_strb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && axi_w_ready_i |-> axi_w_strb_o == exp_strb)
    else begin
      data_errors++;
      $display("FAIL beat_strb: expected %h, actual %h", $sampled(exp_strb),
               $sampled(axi_w_strb_o));
    end

  // No beat beyond the bytes of the accepted instructions
  a_beat_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && axi_w_ready_i |-> exp_beat)
    else begin
      ctrl_errors++;
      $display("W beat sent although no instruction bytes were left");
    end

  a_burst_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && axi_w_ready_i |-> axi_w_last_o == exp_last)
    else begin
      ctrl_errors++;
      $display("FAIL burst_last: expected %b, actual %b", $sampled(exp_last),
               $sampled(axi_w_last_o));
    end

  // Burst consumed with its last beat and at no other time
  a_addrgen_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addrgen_ready_o == (axi_w_valid_o && axi_w_ready_i && exp_last))
    else begin
      ctrl_errors++;
      $display("FAIL addrgen_ready: expected %b, actual %b",
               $sampled(axi_w_valid_o && axi_w_ready_i && exp_last),
               $sampled(addrgen_ready_o));
    end

  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && !axi_w_ready_i |=> axi_w_valid_o)
    else begin
      ctrl_errors++;
      $display("W valid dropped before the stalled beat was taken");
    end

  a_vinsn_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_vinsn_done_o == exp_done)
    else begin
      ctrl_errors++;
      $display("FAIL vinsn_done: expected %h, actual %h", $sampled(exp_done),
               $sampled(pe_vinsn_done_o));
    end

  a_req_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_ready_o == exp_req_ready)
    else begin
      ctrl_errors++;
      $display("FAIL req_ready: expected %b, actual %b", $sampled(exp_req_ready),
               $sampled(pe_req_ready_o));
    end

  a_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_pending_o == exp_pending)
    else begin
      ctrl_errors++;
      $display("FAIL store_pending: expected %b, actual %b", $sampled(exp_pending),
               $sampled(store_pending_o));
    end

  //////////////////////////////////////////////////
  // Sequence tasks
  //////////////////////////////////////////////////

  task automatic finish_run();
    $display("Errors: data %0d, control %0d, timeout %0d", data_errors, ctrl_errors,
             timeout_errors);
    if (data_errors + ctrl_errors + timeout_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeout_errors++;
    $display("Timeout after %0d cycles waiting for %s", MaxWait, what);
    finish_run();
  endtask

  // Queue the bursts of one instruction, then offer it to the DUT
  task automatic send_insn(input vinsn_id_t id, input vl_t vl, input vsew_t vsew);
    int unsigned beats;
    int unsigned len;
    int unsigned cycles;
    beats = ((int'(vl) << vsew) + BeatBytes - 1) / BeatBytes;
    beats_expected += beats;
    while (beats > 0) begin
      len = rand_bits(2) + 1;
      if (len > beats) len = beats;
      burst_q.push_back(axi_len_t'(len - 1));
      beats -= len;
    end
    pe_req_valid_i = 1'b1;
    pe_req_id_i    = id;
    pe_req_vl_i    = vl;
    pe_req_vsew_i  = vsew;
    cycles         = 0;
    @(posedge clk_i);
    while (!pe_req_ready_o) begin
      cycles++;
      if (cycles >= MaxWait) timed_out("an instruction accept");
      @(posedge clk_i);
    end
    #1;
    pe_req_valid_i = 1'b0;
  endtask

  task automatic send_b();
    int unsigned cycles;
    axi_b_valid_i = 1'b1;
    cycles        = 0;
    @(posedge clk_i);
    while (!axi_b_ready_o) begin
      cycles++;
      if (cycles >= MaxWait) timed_out("B ready");
      @(posedge clk_i);
    end
    #1;
    axi_b_valid_i = 1'b0;
  endtask

  task automatic wait_all_issued();
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles >= MaxWait) timed_out("the last W beat");
    end while (unissued_id_q.size() != 0);
  endtask

  task automatic wait_one_issued();
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles >= MaxWait) timed_out("an issued instruction");
    end while (issued_q.size() == 0);
  endtask

  task automatic wait_drained();
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles >= MaxWait) timed_out("the queue to drain");
    end while (occupancy != 0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    int unsigned id_cnt;
    int unsigned n;
    lfsr_q              = 32'h7b2f_3b8d;
    rst_ni              = 1'b0;
    pe_req_valid_i      = 1'b0;
    pe_req_id_i         = '0;
    pe_req_vl_i         = '0;
    pe_req_vsew_i       = '0;
    stu_operand_i       = '0;
    stu_operand_valid_i = '0;
    addrgen_valid_i     = 1'b0;
    addrgen_len_i       = '0;
    axi_w_ready_i       = 1'b0;
    axi_b_valid_i       = 1'b0;
    exp_data            = '0;
    exp_strb            = '0;
    exp_last            = 1'b0;
    exp_beat            = 1'b0;
    exp_req_ready       = 1'b1;
    exp_pending         = 1'b0;
    exp_done            = '0;
    rem_bytes           = 0;
    beat_in_burst       = 0;
    occupancy           = 0;
    beats_seen          = 0;
    beats_expected      = 0;
    data_errors         = 0;
    ctrl_errors         = 0;
    timeout_errors      = 0;
    id_cnt              = 0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // B with nothing issued must not report a done
    send_b();

    // Four stores and no B fill the queue
    send_insn(vinsn_id_t'(0), vl_t'(5), vsew_t'(3));
    send_insn(vinsn_id_t'(1), vl_t'(32), vsew_t'(0));
    send_insn(vinsn_id_t'(2), vl_t'(100), vsew_t'(2));
    send_insn(vinsn_id_t'(3), vl_t'(1), vsew_t'(1));
    id_cnt = 4;
    a_queue_full: assert (!pe_req_ready_o)
      else begin
        ctrl_errors++;
        $display("FAIL queue_full: expected 0, actual %b", pe_req_ready_o);
      end
    wait_all_issued();
    repeat (4) send_b();
    wait_drained();

    // Random lengths with B responses mixed in
    for (int i = 0; i < 16; i++) begin
      // One idle cycle lets the model see the last handshake
      @(posedge clk_i);
      #1;
      if (occupancy == InsnQueueDepth) begin
        wait_one_issued();
        send_b();
      end
      send_insn(vinsn_id_t'(id_cnt % NrVInsn), vl_t'(rand_bits(6) + 1), vsew_t'(rand_bits(2)));
      id_cnt++;
      if (issued_q.size() > 0 && rand_bits(1)) send_b();
    end

    // Commit whatever is still outstanding
    wait_all_issued();
    n = occupancy;
    repeat (n) send_b();
    wait_drained();

    a_beat_total: assert (beats_seen == beats_expected)
      else begin
        ctrl_errors++;
        $display("FAIL beat_total: expected %0d, actual %0d", beats_expected, beats_seen);
      end
    finish_run();
  end

endmodule

// ==== vstu_lite.f ====
src/vstu_pkg.sv
src/vstu_insn_queue.sv
src/vstu_operand_reg.sv
src/vstu_beat_packer.sv
src/vstu_top.sv
verif/tb_vstu.sv

// ==== Bender.yml ====
package:
  name: vstu_lite

sources:
  - src/vstu_pkg.sv
  - src/vstu_insn_queue.sv
  - src/vstu_operand_reg.sv
  - src/vstu_beat_packer.sv
  - src/vstu_top.sv
  - target: test
    files:
      - verif/tb_vstu.sv
